//--- source/soc_pkg.sv
// SoC slice definitions
// APB widths, address map and register offsets shared by all blocks
package soc_pkg;

  // APB bus widths
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  // Offset width inside one 256-byte slave window
  localparam int OFS_W = 8;

  // Slave windows, each 256 bytes long
  localparam logic [APB_ADDR_W-1:0] GPIO_BASE = 12'h000;
  localparam logic [APB_ADDR_W-1:0] PRCI_BASE = 12'h100;

  // GPIO registers
  // Output value, read and write
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 8'h00;
  // Direction, 1 drives the pad
  localparam logic [OFS_W-1:0] GPIO_DIR_OFS = 8'h04;
  // Synchronized pad value, read only
  localparam logic [OFS_W-1:0] GPIO_IN_OFS = 8'h08;

  // PRCI registers
  // Status: bit 0 PLL lock, bit 1 DDR calib done, bit 2 system running
  localparam logic [OFS_W-1:0] PRCI_STATUS_OFS = 8'h00;
  // Soft reset: writing 1 to bit 0 restarts the system reset sequence
  localparam logic [OFS_W-1:0] PRCI_SRST_OFS = 8'h04;

  // Status register bit positions
  localparam int PRCI_ST_PLL_BIT = 0;
  localparam int PRCI_ST_DDR_BIT = 1;
  localparam int PRCI_ST_RUN_BIT = 2;

endpackage

//--- source/apb_decoder.sv
// APB address decoder
// Selects GPIO or PRCI by address window, muxes read data, flags unmapped access
`timescale 1ns/1ps

module apb_decoder (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_apb_psel,
  input  logic                              i_apb_penable,
  input  logic                              i_apb_pwrite,
  input  logic [soc_pkg::APB_ADDR_W-1:0]    i_apb_paddr,
  output logic [soc_pkg::APB_DATA_W-1:0]    o_apb_prdata,
  output logic                              o_apb_pready,
  output logic                              o_apb_pslverr,
  output logic                              o_gpio_psel,
  output logic                              o_prci_psel,
  output logic [soc_pkg::OFS_W-1:0]         o_offset,
  input  logic [soc_pkg::APB_DATA_W-1:0]    i_gpio_prdata,
  input  logic [soc_pkg::APB_DATA_W-1:0]    i_prci_prdata
);

  localparam int HI = soc_pkg::APB_ADDR_W - 1;
  localparam int LO = soc_pkg::OFS_W;

  logic w_gpio_hit;
  logic w_prci_hit;
  logic w_unmapped;
  logic w_setup;
  logic r_err;

  // Window match on the upper address bits
  assign w_gpio_hit = (i_apb_paddr[HI:LO] == soc_pkg::GPIO_BASE[HI:LO]);
  assign w_prci_hit = (i_apb_paddr[HI:LO] == soc_pkg::PRCI_BASE[HI:LO]);
  assign w_unmapped = !w_gpio_hit && !w_prci_hit;
  assign w_setup    = i_apb_psel && !i_apb_penable;

  // Error state of the current transfer, captured in its setup cycle
  // and kept until the next one
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_err <= 1'b0;
    end else if (w_setup) begin
      r_err <= w_unmapped;
    end
  end

  assign o_gpio_psel = i_apb_psel && w_gpio_hit;
  assign o_prci_psel = i_apb_psel && w_prci_hit;
  assign o_offset    = i_apb_paddr[soc_pkg::OFS_W-1:0];

  // Unmapped reads return 0
  always_comb begin
    if (w_gpio_hit) begin
      o_apb_prdata = i_gpio_prdata;
    end else if (w_prci_hit) begin
      o_apb_prdata = i_prci_prdata;
    end else begin
      o_apb_prdata = '0;
    end
  end

  // No wait states anywhere in the slice
  assign o_apb_pready  = 1'b1;
  assign o_apb_pslverr = i_apb_psel && i_apb_penable && r_err;

endmodule

//--- source/apb_prci.sv
// PLL and reset control block
// Sequences system and debug resets from lock inputs and a soft reset on APB
`timescale 1ns/1ps

module apb_prci #(
  parameter int reset_delay = 16
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_sys_locked,
  input  logic                              i_ddr_locked,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  logic [soc_pkg::OFS_W-1:0]         i_offset,
  input  logic [soc_pkg::APB_DATA_W-1:0]    i_pwdata,
  output logic [soc_pkg::APB_DATA_W-1:0]    o_prdata,
  output logic                              o_sys_rst,
  output logic                              o_sys_nrst,
  output logic                              o_dbg_nrst
);

  // Counter width and start value; the sync stages take 3 of the cycles
  localparam int CNT_W = $clog2(reset_delay);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(reset_delay - 3);

  logic [1:0]       r_lock_meta;
  logic [1:0]       r_lock_sync;
  logic [1:0]       r_soft_req;
  logic [CNT_W-1:0] r_cnt;
  logic             r_sys_rst;
  logic             r_dbg_nrst;
  logic             w_soft_wr;
  logic             w_locks_raw;
  logic             w_locks_sync;
  logic             w_hold;

  // Soft reset is taken at the end of the access cycle
  assign w_soft_wr = i_psel && i_penable && i_pwrite &&
                     (i_offset == soc_pkg::PRCI_SRST_OFS) && i_pwdata[0];

  assign w_locks_raw  = i_sys_locked && i_ddr_locked;
  assign w_locks_sync = &r_lock_sync;

  // A falling lock asserts reset at once, release waits for the synchronizer
  assign w_hold = i_reset || !w_locks_raw || !w_locks_sync || w_soft_wr || (|r_soft_req);

  // Two-flop synchronizer, bit 0 PLL, bit 1 DDR
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_lock_meta <= 2'b00;
      r_lock_sync <= 2'b00;
    end else begin
      r_lock_meta <= {i_ddr_locked, i_sys_locked};
      r_lock_sync <= r_lock_meta;
    end
  end

  // Soft request stays pending for as long as a lock takes through the sync
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_soft_req <= 2'b00;
    end else begin
      r_soft_req <= {r_soft_req[0], w_soft_wr};
    end
  end

  // Release down-counter
  always_ff @(posedge i_clk) begin
    if (w_hold) begin
      r_cnt     <= CNT_LOAD;
      r_sys_rst <= 1'b1;
    end else if (r_cnt != '0) begin
      r_cnt <= r_cnt - 1'b1;
    end else begin
      r_sys_rst <= 1'b0;
    end
  end

  // Debug reset only sees the power-on reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_dbg_nrst <= 1'b0;
    end else begin
      r_dbg_nrst <= 1'b1;
    end
  end

  // Register read mux, soft-reset register reads back as 0
  always_comb begin
    o_prdata = '0;
    if (i_offset == soc_pkg::PRCI_STATUS_OFS) begin
      o_prdata[soc_pkg::PRCI_ST_PLL_BIT] = r_lock_sync[0];
      o_prdata[soc_pkg::PRCI_ST_DDR_BIT] = r_lock_sync[1];
      o_prdata[soc_pkg::PRCI_ST_RUN_BIT] = !r_sys_rst;
    end
  end

  assign o_sys_rst  = r_sys_rst;
  assign o_sys_nrst = !r_sys_rst;
  assign o_dbg_nrst = r_dbg_nrst;

endmodule

//--- source/apb_gpio.sv
// GPIO block with tri-state pads
// Output and direction registers on APB, pad inputs through a two-flop sync
`timescale 1ns/1ps

module apb_gpio #(
  parameter int gpio_width = 12
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  logic [soc_pkg::OFS_W-1:0]         i_offset,
  input  logic [soc_pkg::APB_DATA_W-1:0]    i_pwdata,
  output logic [soc_pkg::APB_DATA_W-1:0]    o_prdata,
  inout  wire  [gpio_width-1:0]             io_gpio
);

  logic [gpio_width-1:0] r_out;
  logic [gpio_width-1:0] r_dir;
  logic [gpio_width-1:0] r_in_meta;
  logic [gpio_width-1:0] r_in_sync;
  logic                  w_wr;

  assign w_wr = i_psel && i_penable && i_pwrite;

  // Register writes at the end of the access cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_out <= '0;
      r_dir <= '0;
    end else if (w_wr) begin
      case (i_offset)
        soc_pkg::GPIO_OUT_OFS: r_out <= i_pwdata[gpio_width-1:0];
        soc_pkg::GPIO_DIR_OFS: r_dir <= i_pwdata[gpio_width-1:0];
        default: ;
      endcase
    end
  end

  // Pad input synchronizer
  always_ff @(posedge i_clk) begin
    r_in_meta <= io_gpio;
    r_in_sync <= r_in_meta;
  end

  // Each pad is driven only when its direction bit is set
  genvar g;
  generate
    for (g = 0; g < gpio_width; g++) begin : g_pad
      assign io_gpio[g] = r_dir[g] ? r_out[g] : 1'bz;
    end
  endgenerate

  // Read mux, zero extended to the bus width
  always_comb begin
    o_prdata = '0;
    case (i_offset)
      soc_pkg::GPIO_OUT_OFS: o_prdata[gpio_width-1:0] = r_out;
      soc_pkg::GPIO_DIR_OFS: o_prdata[gpio_width-1:0] = r_dir;
      soc_pkg::GPIO_IN_OFS:  o_prdata[gpio_width-1:0] = r_in_sync;
      default:               o_prdata = '0;
    endcase
  end

endmodule

//--- source/asic_top.sv
// Chip-top slice of the SoC
// APB decoder, reset controller and GPIO pads on a single clock
`timescale 1ns/1ps

module asic_top #(
  parameter int gpio_width  = 12,
  parameter int reset_delay = 16
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_sys_locked,
  input  logic                              i_ddr_locked,
  // APB slave port
  input  logic                              i_apb_psel,
  input  logic                              i_apb_penable,
  input  logic                              i_apb_pwrite,
  input  logic [soc_pkg::APB_ADDR_W-1:0]    i_apb_paddr,
  input  logic [soc_pkg::APB_DATA_W-1:0]    i_apb_pwdata,
  output logic [soc_pkg::APB_DATA_W-1:0]    o_apb_prdata,
  output logic                              o_apb_pready,
  output logic                              o_apb_pslverr,
  // Pads
  inout  wire  [gpio_width-1:0]             io_gpio,
  output logic                              o_sys_nrst,
  output logic                              o_dbg_nrst
);

  logic                           w_gpio_psel;
  logic                           w_prci_psel;
  logic [soc_pkg::OFS_W-1:0]      w_offset;
  logic [soc_pkg::APB_DATA_W-1:0] w_gpio_prdata;
  logic [soc_pkg::APB_DATA_W-1:0] w_prci_prdata;
  logic                           w_sys_rst;

  apb_decoder dec0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_apb_psel(i_apb_psel),
    .i_apb_penable(i_apb_penable),
    .i_apb_pwrite(i_apb_pwrite),
    .i_apb_paddr(i_apb_paddr),
    .o_apb_prdata(o_apb_prdata),
    .o_apb_pready(o_apb_pready),
    .o_apb_pslverr(o_apb_pslverr),
    .o_gpio_psel(w_gpio_psel),
    .o_prci_psel(w_prci_psel),
    .o_offset(w_offset),
    .i_gpio_prdata(w_gpio_prdata),
    .i_prci_prdata(w_prci_prdata)
  );

  // Reset controller stays on the power-on reset
  apb_prci #(
    .reset_delay(reset_delay)
  ) prci0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sys_locked(i_sys_locked),
    .i_ddr_locked(i_ddr_locked),
    .i_psel(w_prci_psel),
    .i_penable(i_apb_penable),
    .i_pwrite(i_apb_pwrite),
    .i_offset(w_offset),
    .i_pwdata(i_apb_pwdata),
    .o_prdata(w_prci_prdata),
    .o_sys_rst(w_sys_rst),
    .o_sys_nrst(o_sys_nrst),
    .o_dbg_nrst(o_dbg_nrst)
  );

  // GPIO runs on the system reset
  apb_gpio #(
    .gpio_width(gpio_width)
  ) gpio0 (
    .i_clk(i_clk),
    .i_reset(w_sys_rst),
    .i_psel(w_gpio_psel),
    .i_penable(i_apb_penable),
    .i_pwrite(i_apb_pwrite),
    .i_offset(w_offset),
    .i_pwdata(i_apb_pwdata),
    .o_prdata(w_gpio_prdata),
    .io_gpio(io_gpio)
  );

endmodule

//--- sim/asic_top_properties.sv
// APB protocol and reset sequencing assertions for the chip-top slice
`timescale 1ns/1ps

module asic_top_properties (
  input logic i_clk,
  input logic i_reset,
  input logic i_sys_locked,
  input logic i_ddr_locked,
  input logic i_apb_psel,
  input logic i_apb_penable,
  input logic i_apb_pready,
  input logic i_apb_pslverr,
  input logic i_sys_nrst
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // Access phase always comes with a select
  penable_needs_psel: assert property (
    @(posedge i_clk) disable iff (i_reset) i_apb_penable |-> i_apb_psel
  ) else begin
    fail_count++;
    $error("APB penable high without psel");
  end

  pready_tied_high: assert property (
    @(posedge i_clk) disable iff (i_reset) i_apb_pready
  ) else begin
    fail_count++;
    $error("APB pready dropped low");
  end

  pslverr_in_access: assert property (
    @(posedge i_clk) disable iff (i_reset) i_apb_pslverr |-> (i_apb_psel && i_apb_penable)
  ) else begin
    fail_count++;
    $error("APB pslverr outside an access cycle");
  end

  // A missing lock holds the system in reset from the next edge on
  sys_reset_without_locks: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(i_sys_locked && i_ddr_locked) |=> !i_sys_nrst
  ) else begin
    fail_count++;
    $error("System reset released while a lock input is low");
  end

endmodule

bind asic_top asic_top_properties props0 (
  .i_clk(i_clk),
  .i_reset(i_reset),
  .i_sys_locked(i_sys_locked),
  .i_ddr_locked(i_ddr_locked),
  .i_apb_psel(i_apb_psel),
  .i_apb_penable(i_apb_penable),
  .i_apb_pready(o_apb_pready),
  .i_apb_pslverr(o_apb_pslverr),
  .i_sys_nrst(o_sys_nrst)
);

//--- sim/tb_asic_top.sv
// Testbench for the chip-top slice
// Drives APB and the lock inputs, models the pads and checks resets and registers
`timescale 1ns/1ps

module tb_asic_top;

  localparam int GPIO_WIDTH  = 12;
  localparam int RESET_DELAY = 16;
  localparam int CLK_PERIOD  = 8;
  localparam int REG_ROUNDS  = 8;
  localparam int PAD_ROUNDS  = 6;

  // Register addresses
  localparam logic [11:0] A_OUT    = soc_pkg::GPIO_BASE | {4'h0, soc_pkg::GPIO_OUT_OFS};
  localparam logic [11:0] A_DIR    = soc_pkg::GPIO_BASE | {4'h0, soc_pkg::GPIO_DIR_OFS};
  localparam logic [11:0] A_IN     = soc_pkg::GPIO_BASE | {4'h0, soc_pkg::GPIO_IN_OFS};
  localparam logic [11:0] A_STATUS = soc_pkg::PRCI_BASE | {4'h0, soc_pkg::PRCI_STATUS_OFS};
  localparam logic [11:0] A_SRST   = soc_pkg::PRCI_BASE | {4'h0, soc_pkg::PRCI_SRST_OFS};
  // Addresses outside both windows
  // 0x204 mirrors the soft reset offset
  localparam logic [11:0] BAD_ADDR [4] = '{12'h200, 12'h204, 12'h508, 12'hffc};

  // Cycle budget per test
  // An APB access takes 2 cycles
  localparam int RESET_TEST_CYCLES    = 2 * (RESET_DELAY + 2) + 40;
  localparam int REG_TEST_CYCLES      = REG_ROUNDS * 4 * 2;
  localparam int PAD_TEST_CYCLES      = PAD_ROUNDS * (3 * 2 + 2);
  localparam int SOFT_TEST_CYCLES     = (RESET_DELAY + 2) + 9 * 2;
  localparam int UNMAPPED_TEST_CYCLES = 4 * 2 * 2 + 8 * 2;
  localparam int WATCHDOG_CYCLES      = RESET_TEST_CYCLES + REG_TEST_CYCLES +
                                        PAD_TEST_CYCLES + SOFT_TEST_CYCLES +
                                        UNMAPPED_TEST_CYCLES + 200;

  logic                           clk = 1'b0;
  logic                           reset;
  logic                           sys_locked;
  logic                           ddr_locked;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [soc_pkg::APB_ADDR_W-1:0] paddr;
  logic [soc_pkg::APB_DATA_W-1:0] pwdata;
  logic [soc_pkg::APB_DATA_W-1:0] prdata;
  logic                           pready;
  logic                           pslverr;
  logic                           sys_nrst;
  logic                           dbg_nrst;
  wire  [GPIO_WIDTH-1:0]          gpio;

  // Expected register state
  logic [GPIO_WIDTH-1:0] exp_out;
  logic [GPIO_WIDTH-1:0] exp_dir;
  logic [GPIO_WIDTH-1:0] pad_val;
  logic                  exp_run;
  integer                seed = 32'h09b892dc;
  logic [31:0]           rand_word;

  // Read sample passed to the compare process
  string       rd_name;
  logic [11:0] rd_addr;
  logic [31:0] rd_data;
  logic        rd_slverr;
  event        read_sampled;

  // External pad drivers on the pins the DUT leaves at Z
  genvar g;
  generate
    for (g = 0; g < GPIO_WIDTH; g++) begin : g_pad_model
      assign gpio[g] = exp_dir[g] ? 1'bz : pad_val[g];
    end
  endgenerate

  asic_top #(
    .gpio_width(GPIO_WIDTH),
    .reset_delay(RESET_DELAY)
  ) DUT (
    .i_clk(clk),
    .i_reset(reset),
    .i_sys_locked(sys_locked),
    .i_ddr_locked(ddr_locked),
    .i_apb_psel(psel),
    .i_apb_penable(penable),
    .i_apb_pwrite(pwrite),
    .i_apb_paddr(paddr),
    .i_apb_pwdata(pwdata),
    .o_apb_prdata(prdata),
    .o_apb_pready(pready),
    .o_apb_pslverr(pslverr),
    .io_gpio(gpio),
    .o_sys_nrst(sys_nrst),
    .o_dbg_nrst(dbg_nrst)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Register map as seen from the bus
  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      A_OUT:    v[GPIO_WIDTH-1:0] = exp_out;
      A_DIR:    v[GPIO_WIDTH-1:0] = exp_dir;
      A_IN:     v[GPIO_WIDTH-1:0] = (exp_dir & exp_out) | (~exp_dir & pad_val);
      A_STATUS: v[2:0] = {exp_run, ddr_locked, sys_locked};
      default:  v = '0;
    endcase
    return v;
  endfunction

  function automatic logic unmapped(input logic [11:0] addr);
    return addr >= 12'h200;
  endfunction

  // Release rule
  // n counts edges from the last lock or the soft reset write
  function automatic logic released_after(input int n);
    return n >= RESET_DELAY;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    logic slverr;
    logic ready;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    @(negedge clk);
    slverr = pslverr;
    ready  = pready;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    check_value("write pready", 32'd1, {31'b0, ready});
    check_value("write pslverr", {31'b0, unmapped(addr)}, {31'b0, slverr});
    // The write landed on the edge that ended the access cycle
    case (addr)
      A_OUT: if (exp_run) exp_out = data[GPIO_WIDTH-1:0];
      A_DIR: if (exp_run) exp_dir = data[GPIO_WIDTH-1:0];
      A_SRST: begin
        if (data[0]) begin
          exp_out = '0;
          exp_dir = '0;
          exp_run = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  task automatic read_reg(input string name, input logic [11:0] addr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    @(negedge clk);
    check_value({name, " pready"}, 32'd1, {31'b0, pready});
    rd_name   = name;
    rd_addr   = addr;
    rd_data   = prdata;
    rd_slverr = pslverr;
    -> read_sampled;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Follows o_sys_nrst edge by edge until past the release point
  task automatic follow_release(input string name);
    for (int n = 1; n <= RESET_DELAY + 2; n++) begin
      next_cycle();
      check_value(name, {31'b0, released_after(n)}, {31'b0, sys_nrst});
    end
    exp_run = 1'b1;
  endtask

  always @(read_sampled) begin
    check_value(rd_name, expected_read(rd_addr), rd_data);
    check_value({rd_name, " pslverr"}, {31'b0, unmapped(rd_addr)}, {31'b0, rd_slverr});
  end

  always @(DUT.props0.fail_count) begin
    if (DUT.props0.fail_count != 0) begin
      $display("A bound assertion on the DUT failed");
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first assertion failure");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Simulation timed out");
  end

  initial begin
    reset      = 1'b1;
    sys_locked = 1'b0;
    ddr_locked = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    exp_out    = '0;
    exp_dir    = '0;
    pad_val    = '0;
    exp_run    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset release from the locks
    check_value("dbg reset held", 32'd0, {31'b0, dbg_nrst});
    next_cycle();
    check_value("dbg reset released", 32'd1, {31'b0, dbg_nrst});
    sys_locked = 1'b1;
    repeat (4) begin
      next_cycle();
      check_value("sys reset with pll only", 32'd0, {31'b0, sys_nrst});
    end
    ddr_locked = 1'b1;
    follow_release("release after both locks");
    read_reg("status running", A_STATUS);
    ddr_locked = 1'b0;
    next_cycle();
    check_value("sys reset on lock loss", 32'd0, {31'b0, sys_nrst});
    check_value("dbg reset ignores locks", 32'd1, {31'b0, dbg_nrst});
    exp_run = 1'b0;
    next_cycle();
    next_cycle();
    read_reg("status ddr unlocked", A_STATUS);
    ddr_locked = 1'b1;
    follow_release("release after relock");

    // Register readback
    repeat (REG_ROUNDS) begin
      rand_word = $random(seed);
      write_reg(A_OUT, rand_word);
      rand_word = $random(seed);
      write_reg(A_DIR, rand_word);
      read_reg("out readback", A_OUT);
      read_reg("dir readback", A_DIR);
    end

    // Pads in both directions
    repeat (PAD_ROUNDS) begin
      rand_word = $random(seed);
      write_reg(A_DIR, rand_word);
      rand_word = $random(seed);
      write_reg(A_OUT, rand_word);
      rand_word = $random(seed);
      pad_val = rand_word[GPIO_WIDTH-1:0];
      next_cycle();
      next_cycle();
      check_value("pads driven", 32'(exp_out & exp_dir), 32'(gpio & exp_dir));
      read_reg("pad input", A_IN);
    end

    // Status and soft reset
    write_reg(A_OUT, 32'h0000_0fff);
    write_reg(A_DIR, 32'h0000_0ff0);
    read_reg("status before soft reset", A_STATUS);
    write_reg(A_SRST, 32'h0);
    check_value("zero write keeps running", 32'd1, {31'b0, sys_nrst});
    write_reg(A_SRST, 32'h1);
    check_value("soft reset asserted", 32'd0, {31'b0, sys_nrst});
    follow_release("soft reset release");
    read_reg("out cleared", A_OUT);
    read_reg("dir cleared", A_DIR);
    read_reg("status after soft reset", A_STATUS);

    // Unmapped addresses
    write_reg(A_OUT, 32'h0000_0a5a);
    write_reg(A_DIR, 32'h0000_00f0);
    for (int i = 0; i < 4; i++) begin
      rand_word = $random(seed);
      write_reg(BAD_ADDR[i], rand_word | 32'h1);
      check_value("unmapped write keeps running", 32'd1, {31'b0, sys_nrst});
      read_reg("unmapped read", BAD_ADDR[i]);
    end
    read_reg("out after unmapped", A_OUT);
    read_reg("dir after unmapped", A_DIR);
    read_reg("status after unmapped", A_STATUS);

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- project.f
source/soc_pkg.sv
source/apb_decoder.sv
source/apb_prci.sv
source/apb_gpio.sv
source/asic_top.sv
sim/asic_top_properties.sv
sim/tb_asic_top.sv

//--- Bender.yml
package:
  name: asic_top_slice

sources:
  # RTL in compile order
  - files:
      - source/soc_pkg.sv
      - source/apb_decoder.sv
      - source/apb_prci.sv
      - source/apb_gpio.sv
      - source/asic_top.sv
  # Bound assertions and testbench
  - target: simulation
    files:
      - sim/asic_top_properties.sv
      - sim/tb_asic_top.sv
